//--- include/dma_params.svh
// ##############################
// DMA engine parameters
// Widths, tile geometry, kernel size
// and the init record length
// ##############################

`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Bus and field widths
`define DMA_ADDR_W     32 // External word address
`define DMA_DATA_W     32 // Data word
`define DMA_DIM_W      8  // Spatial dimension
`define DMA_CH_W       11 // Channel count
`define DMA_BUF_ADDR_W 12 // Tile buffer address

// Input tile including halo
`define DMA_TIX 6
`define DMA_TIY 6

// Output tile at stride 1
`define DMA_TOX 4
`define DMA_TOY 4

// Kernel size, half of it is the halo width
`define DMA_NKX 3
`define DMA_NKY 3

`define DMA_INIT_WORDS 4 // Words in the layer record

`endif

//--- source/dma_pkg.sv
// ##############################
// DMA engine types
// Opcodes, controller states and
// the command and config records
// ##############################

`default_nettype none

`include "dma_params.svh"

package dma_pkg;

	// Operation codes, any other value is ignored
	typedef enum logic [2:0] {
		OP_INIT      = 3'd0,
		OP_LOAD_FMI  = 3'd1,
		OP_STORE_FMO = 3'd5
	} dma_op_e;

	// Controller FSM
	typedef enum logic [2:0] {
		IDLE,
		INIT_RD,  // Waiting on a record word
		INIT_WR,  // Record word goes to the register block
		RUN_FMI,  // Input tile walker busy
		RUN_FMO,  // Output tile walker busy
		FINISHED  // One cycle done pulse
	} dma_state_e;

	// Layer record as stored
	typedef struct packed {
		logic [`DMA_DIM_W-1:0]  nix;
		logic [`DMA_DIM_W-1:0]  niy;
		logic                   stride; // 0 for stride 1, 1 for stride 2
		logic [`DMA_CH_W-1:0]   nif;
		logic [`DMA_CH_W-1:0]   nof;
		logic [`DMA_ADDR_W-1:0] ifm_base;
		logic [`DMA_ADDR_W-1:0] ofm_base;
	} layer_cfg_t;

	// Geometry derived from the record
	typedef struct packed {
		logic [`DMA_DIM_W-1:0]  nox;
		logic [`DMA_DIM_W-1:0]  noy;
		logic [`DMA_DIM_W-1:0]  tox;
		logic [`DMA_DIM_W-1:0]  toy;
		logic [`DMA_ADDR_W-1:0] fmi_plane; // nix * niy
		logic [`DMA_ADDR_W-1:0] fmo_plane; // nox * noy
	} layer_geo_t;

	// External memory command
	typedef struct packed {
		logic                   rd_req; // Single cycle pulse
		logic                   wr;     // Single cycle strobe
		logic [`DMA_ADDR_W-1:0] addr;
		logic [`DMA_DATA_W-1:0] wdata;
	} ext_req_t;

	// Tile buffer command
	typedef struct packed {
		logic                       fmi_wr; // Input buffer write strobe
		logic                       fmo_rd; // Output buffer read enable, level
		logic [`DMA_BUF_ADDR_W-1:0] addr;
		logic [`DMA_DATA_W-1:0]     wdata;
	} buf_req_t;

endpackage

`default_nettype wire

//--- source/dma_layer_regs.sv
// ##############################
// Layer configuration registers
// Stores the init record and keeps
// the output geometry precomputed
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_layer_regs (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   load_i,     // Capture strobe
	input  wire logic [1:0]             word_idx_i, // Which record word
	input  wire logic [`DMA_DATA_W-1:0] word_i,
	output dma_pkg::layer_cfg_t         cfg_o,
	output dma_pkg::layer_geo_t         geo_o
);

	dma_pkg::layer_cfg_t   cfg_q;
	dma_pkg::layer_geo_t   geo_q;
	logic [`DMA_DIM_W-1:0] nox_c, noy_c;

	// Output size halves at stride 2
	assign nox_c = cfg_q.nix >> cfg_q.stride;
	assign noy_c = cfg_q.niy >> cfg_q.stride;

	// Record capture, one field group per word
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cfg_q <= '0;
		end else if (load_i) begin
			case (word_idx_i)
				2'd0: begin
					cfg_q.nix    <= word_i[7:0];
					cfg_q.niy    <= word_i[15:8];
					cfg_q.stride <= word_i[19];
				end
				2'd1: begin
					cfg_q.nif <= word_i[10:0];
					cfg_q.nof <= word_i[22:12];
				end
				2'd2: cfg_q.ifm_base <= word_i;
				default: cfg_q.ofm_base <= word_i;
			endcase
		end
	end

	// Registered geometry, keeps multipliers out of the walkers
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			geo_q <= '0;
		end else begin
			geo_q.nox <= nox_c;
			geo_q.noy <= noy_c;
			geo_q.tox <= `DMA_DIM_W'(`DMA_TOX) >> cfg_q.stride;
			geo_q.toy <= `DMA_DIM_W'(`DMA_TOY) >> cfg_q.stride;
			geo_q.fmi_plane <= `DMA_ADDR_W'(cfg_q.nix) * `DMA_ADDR_W'(cfg_q.niy);
			geo_q.fmo_plane <= `DMA_ADDR_W'(nox_c) * `DMA_ADDR_W'(noy_c);
		end
	end

	assign cfg_o = cfg_q;
	assign geo_o = geo_q;

endmodule

`default_nettype wire

//--- source/dma_ctrl.sv
// ##############################
// DMA controller
// Opcode decode, init record fetch,
// walker launch and port selection
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_ctrl (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   start_i,
	input  wire dma_pkg::dma_op_e       op_i,
	input  wire logic [`DMA_DIM_W-1:0]  tx_i,
	input  wire logic [`DMA_DIM_W-1:0]  ty_i,
	input  wire logic                   ext_rvalid_i,
	input  wire logic [`DMA_DATA_W-1:0] ext_rdata_i,
	input  wire dma_pkg::ext_req_t      fmi_ext_i,   // Input walker command
	input  wire dma_pkg::ext_req_t      fmo_ext_i,   // Output walker command
	input  wire logic                   fmi_done_i,
	input  wire logic                   fmo_done_i,
	output logic                        load_o,      // To the layer registers
	output logic [1:0]                  word_idx_o,
	output logic [`DMA_DATA_W-1:0]      word_o,
	output logic                        fmi_start_o,
	output logic                        fmo_start_o,
	output logic [`DMA_DIM_W-1:0]       tile_x_o,
	output logic [`DMA_DIM_W-1:0]       tile_y_o,
	output dma_pkg::ext_req_t           ext_req_o,
	output logic                        done_o
);

	dma_pkg::dma_state_e    state_q, state_d;
	logic [1:0]             idx_q;  // Record word index, doubles as read address
	logic                   req_q;  // First cycle of INIT_RD
	logic [`DMA_DATA_W-1:0] data_q; // Returned record word

	// Next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			dma_pkg::IDLE: begin
				if (start_i) begin
					case (op_i)
						dma_pkg::OP_INIT:      state_d = dma_pkg::INIT_RD;
						dma_pkg::OP_LOAD_FMI:  state_d = dma_pkg::RUN_FMI;
						dma_pkg::OP_STORE_FMO: state_d = dma_pkg::RUN_FMO;
						default:               state_d = dma_pkg::IDLE; // Unknown op dropped
					endcase
				end
			end
			dma_pkg::INIT_RD: if (ext_rvalid_i) state_d = dma_pkg::INIT_WR;
			dma_pkg::INIT_WR: begin
				if (idx_q == 2'(`DMA_INIT_WORDS - 1)) // Last record word
					state_d = dma_pkg::FINISHED;
				else
					state_d = dma_pkg::INIT_RD;
			end
			dma_pkg::RUN_FMI: if (fmi_done_i) state_d = dma_pkg::FINISHED;
			dma_pkg::RUN_FMO: if (fmo_done_i) state_d = dma_pkg::FINISHED;
			default: state_d = dma_pkg::IDLE; // FINISHED lasts one cycle
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state_q <= dma_pkg::IDLE;
			idx_q   <= '0;
			req_q   <= 1'b0;
			data_q  <= '0;
		end else begin
			state_q <= state_d;
			// Request only on entry into INIT_RD
			req_q   <= (state_d == dma_pkg::INIT_RD) && (state_q != dma_pkg::INIT_RD);
			if (state_q == dma_pkg::IDLE)
				idx_q <= '0;
			else if (state_q == dma_pkg::INIT_WR)
				idx_q <= idx_q + 2'd1;
			if (state_q == dma_pkg::INIT_RD && ext_rvalid_i)
				data_q <= ext_rdata_i;
		end
	end

	// Record word handoff
	assign load_o     = (state_q == dma_pkg::INIT_WR);
	assign word_idx_o = idx_q;
	assign word_o     = data_q;

	// Walker launch, registered inside the walkers
	assign fmi_start_o = (state_q == dma_pkg::IDLE) && start_i && (op_i == dma_pkg::OP_LOAD_FMI);
	assign fmo_start_o = (state_q == dma_pkg::IDLE) && start_i && (op_i == dma_pkg::OP_STORE_FMO);
	assign tile_x_o    = tx_i;
	assign tile_y_o    = ty_i;

	// External port owner follows the state
	always_comb begin
		ext_req_o = '0;
		case (state_q)
			dma_pkg::INIT_RD: begin
				ext_req_o.rd_req = req_q;
				ext_req_o.addr   = `DMA_ADDR_W'(idx_q); // Record sits at address 0
			end
			dma_pkg::RUN_FMI: ext_req_o = fmi_ext_i;
			dma_pkg::RUN_FMO: ext_req_o = fmo_ext_i;
			default: ext_req_o = '0;
		endcase
	end

	assign done_o = (state_q == dma_pkg::FINISHED);

endmodule

`default_nettype wire

//--- source/dma_fmi_loader.sv
// ##############################
// Input tile loader
// Walks the padded input tile and
// fills the input buffer, zero pads
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_fmi_loader (
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire logic                       start_i,
	input  wire logic [`DMA_DIM_W-1:0]      tile_x_i, // Padded origin, 0 is halo
	input  wire logic [`DMA_DIM_W-1:0]      tile_y_i,
	input  wire dma_pkg::layer_cfg_t        cfg_i,
	input  wire dma_pkg::layer_geo_t        geo_i,
	input  wire logic                       ext_rvalid_i,
	input  wire logic [`DMA_DATA_W-1:0]     ext_rdata_i,
	output dma_pkg::ext_req_t               ext_o,
	output logic                            fmi_wr_o,
	output logic [`DMA_BUF_ADDR_W-1:0]      buf_addr_o,
	output logic [`DMA_DATA_W-1:0]          buf_wdata_o,
	output logic                            done_o
);

	typedef enum logic [1:0] {FI_IDLE, FI_RD, FI_WR, FI_DONE} fi_state_e;

	fi_state_e                  state_q;
	logic                       req_q;                     // First RD cycle
	logic [`DMA_DIM_W-1:0]      x_q, y_q;                  // Position in tile, 1 based
	logic [`DMA_CH_W-1:0]       c_q;                       // Channel, 1 based
	logic [`DMA_DIM_W-1:0]      tx_q, ty_q, tx0_q, ty0_q;  // Padded map position
	logic [`DMA_ADDR_W-1:0]     row_off_q, row_init_q;     // (ty-1) * nix
	logic [`DMA_ADDR_W-1:0]     ch_off_q;                  // (c-1) * fmi_plane
	logic [`DMA_BUF_ADDR_W-1:0] buf_row_q, buf_ch_q;
	logic [`DMA_DATA_W-1:0]     data_q;
	logic                       pad, row_end, col_end;

	// Halo or outside the map
	assign pad = (tx_q == '0) || (ty_q == '0) || (tx_q > cfg_i.nix) || (ty_q > cfg_i.niy);

	// Tile edge or right/bottom halo reached
	assign row_end = (x_q == `DMA_DIM_W'(`DMA_TIX)) ||
		(tx_q == cfg_i.nix + `DMA_DIM_W'(`DMA_NKX / 2));
	assign col_end = (y_q == `DMA_DIM_W'(`DMA_TIY)) ||
		(ty_q == cfg_i.niy + `DMA_DIM_W'(`DMA_NKY / 2));

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state_q    <= FI_IDLE;
			req_q      <= 1'b0;
			x_q        <= '0;
			y_q        <= '0;
			c_q        <= '0;
			tx_q       <= '0;
			ty_q       <= '0;
			tx0_q      <= '0;
			ty0_q      <= '0;
			row_off_q  <= '0;
			row_init_q <= '0;
			ch_off_q   <= '0;
			buf_row_q  <= '0;
			buf_ch_q   <= '0;
			data_q     <= '0;
		end else begin
			req_q <= 1'b0;
			case (state_q)
				FI_IDLE: begin
					if (start_i) begin
						x_q   <= `DMA_DIM_W'(1);
						y_q   <= `DMA_DIM_W'(1);
						c_q   <= `DMA_CH_W'(1);
						tx_q  <= tile_x_i;
						ty_q  <= tile_y_i;
						tx0_q <= tile_x_i;
						ty0_q <= tile_y_i;
						// Top halo row has no memory row behind it
						if (tile_y_i == '0) begin
							row_init_q <= '0;
							row_off_q  <= '0;
						end else begin
							row_init_q <= `DMA_ADDR_W'(tile_y_i - 1'b1) * `DMA_ADDR_W'(cfg_i.nix);
							row_off_q  <= `DMA_ADDR_W'(tile_y_i - 1'b1) * `DMA_ADDR_W'(cfg_i.nix);
						end
						ch_off_q  <= '0;
						buf_row_q <= '0;
						buf_ch_q  <= '0;
						req_q     <= 1'b1;
						state_q   <= FI_RD;
					end
				end
				FI_RD: begin
					if (pad) begin // Zero without a read
						data_q  <= '0;
						state_q <= FI_WR;
					end else if (ext_rvalid_i) begin
						data_q  <= ext_rdata_i;
						state_q <= FI_WR;
					end
				end
				FI_WR: begin
					req_q   <= 1'b1;
					state_q <= FI_RD;
					if (row_end) begin
						x_q  <= `DMA_DIM_W'(1);
						tx_q <= tx0_q;
						if (col_end) begin
							y_q       <= `DMA_DIM_W'(1);
							ty_q      <= ty0_q;
							row_off_q <= row_init_q;
							buf_row_q <= '0;
							if (c_q == cfg_i.nif) begin // Last channel done
								req_q   <= 1'b0;
								state_q <= FI_DONE;
							end else begin
								c_q      <= c_q + 1'b1;
								ch_off_q <= ch_off_q + geo_i.fmi_plane;
								buf_ch_q <= buf_ch_q + `DMA_BUF_ADDR_W'(`DMA_TIX * `DMA_TIY);
							end
						end else begin
							y_q       <= y_q + 1'b1;
							ty_q      <= ty_q + 1'b1;
							buf_row_q <= buf_row_q + `DMA_BUF_ADDR_W'(`DMA_TIX);
							if (ty_q != '0) // Leaving the top halo keeps row 0
								row_off_q <= row_off_q + `DMA_ADDR_W'(cfg_i.nix);
						end
					end else begin
						x_q  <= x_q + 1'b1;
						tx_q <= tx_q + 1'b1;
					end
				end
				default: state_q <= FI_IDLE; // Done pulse
			endcase
		end
	end

	// Read request on the first RD cycle of a real pixel
	always_comb begin
		ext_o        = '0;
		ext_o.rd_req = (state_q == FI_RD) && req_q && !pad;
		ext_o.addr   = cfg_i.ifm_base + ch_off_q + row_off_q + `DMA_ADDR_W'(tx_q) - 1'b1;
	end

	assign fmi_wr_o    = (state_q == FI_WR);
	assign buf_addr_o  = buf_ch_q + buf_row_q + `DMA_BUF_ADDR_W'(x_q) - 1'b1;
	assign buf_wdata_o = data_q;
	assign done_o      = (state_q == FI_DONE);

endmodule

`default_nettype wire

//--- source/dma_fmo_writer.sv
// ##############################
// Output tile writer
// Flushes the output buffer tile
// to external memory
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_fmo_writer (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   start_i,
	input  wire logic [`DMA_DIM_W-1:0]  tile_x_i, // Output origin, 1 based
	input  wire logic [`DMA_DIM_W-1:0]  tile_y_i,
	input  wire dma_pkg::layer_cfg_t    cfg_i,
	input  wire dma_pkg::layer_geo_t    geo_i,
	input  wire logic [`DMA_DATA_W-1:0] buf_rdata_i,
	output logic                        fmo_rd_o,
	output logic [`DMA_BUF_ADDR_W-1:0]  buf_addr_o,
	output dma_pkg::ext_req_t           ext_o,
	output logic                        done_o
);

	typedef enum logic [2:0] {FO_IDLE, FO_ADDR, FO_RD, FO_WR, FO_DONE} fo_state_e;

	fo_state_e                  state_q;
	logic [`DMA_DIM_W-1:0]      x_q, y_q;                 // Write position in tile
	logic [`DMA_CH_W-1:0]       c_q;
	logic [`DMA_DIM_W-1:0]      tx_q, ty_q, tx0_q, ty0_q; // Output map position
	logic [`DMA_ADDR_W-1:0]     row_off_q, row_init_q;    // (ty-1) * nox
	logic [`DMA_ADDR_W-1:0]     ch_off_q;                 // (c-1) * fmo_plane
	logic [`DMA_BUF_ADDR_W-1:0] buf_x_q, buf_row_q, buf_ch_q;
	logic [`DMA_DATA_W-1:0]     data_q;
	logic                       row_end, col_end;

	// Edges of the current element, shared by buffer and memory walks
	assign row_end = (x_q == geo_i.tox) || (tx_q == geo_i.nox);
	assign col_end = (y_q == geo_i.toy) || (ty_q == geo_i.noy);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state_q    <= FO_IDLE;
			x_q        <= '0;
			y_q        <= '0;
			c_q        <= '0;
			tx_q       <= '0;
			ty_q       <= '0;
			tx0_q      <= '0;
			ty0_q      <= '0;
			row_off_q  <= '0;
			row_init_q <= '0;
			ch_off_q   <= '0;
			buf_x_q    <= '0;
			buf_row_q  <= '0;
			buf_ch_q   <= '0;
			data_q     <= '0;
		end else begin
			case (state_q)
				FO_IDLE: begin
					if (start_i) begin
						x_q        <= `DMA_DIM_W'(1);
						y_q        <= `DMA_DIM_W'(1);
						c_q        <= `DMA_CH_W'(1);
						tx_q       <= tile_x_i;
						ty_q       <= tile_y_i;
						tx0_q      <= tile_x_i;
						ty0_q      <= tile_y_i;
						row_init_q <= `DMA_ADDR_W'(tile_y_i - 1'b1) * `DMA_ADDR_W'(geo_i.nox);
						row_off_q  <= `DMA_ADDR_W'(tile_y_i - 1'b1) * `DMA_ADDR_W'(geo_i.nox);
						ch_off_q   <= '0;
						buf_x_q    <= '0;
						buf_row_q  <= '0;
						buf_ch_q   <= '0;
						state_q    <= FO_ADDR;
					end
				end
				FO_ADDR: state_q <= FO_RD; // First buffer address out
				FO_RD: begin
					data_q  <= buf_rdata_i;
					state_q <= FO_WR;
					// Move the buffer address one element ahead
					if (row_end) begin
						buf_x_q <= '0;
						if (col_end) begin
							buf_row_q <= '0;
							buf_ch_q  <= buf_ch_q + `DMA_BUF_ADDR_W'(`DMA_TOX * `DMA_TOY);
						end else begin
							buf_row_q <= buf_row_q + `DMA_BUF_ADDR_W'(geo_i.tox);
						end
					end else begin
						buf_x_q <= buf_x_q + 1'b1;
					end
				end
				FO_WR: begin
					state_q <= FO_RD;
					if (row_end) begin
						x_q  <= `DMA_DIM_W'(1);
						tx_q <= tx0_q;
						if (col_end) begin
							y_q       <= `DMA_DIM_W'(1);
							ty_q      <= ty0_q;
							row_off_q <= row_init_q;
							if (c_q == cfg_i.nof) begin
								state_q <= FO_DONE;
							end else begin
								c_q      <= c_q + 1'b1;
								ch_off_q <= ch_off_q + geo_i.fmo_plane;
							end
						end else begin
							y_q       <= y_q + 1'b1;
							ty_q      <= ty_q + 1'b1;
							row_off_q <= row_off_q + `DMA_ADDR_W'(geo_i.nox);
						end
					end else begin
						x_q  <= x_q + 1'b1;
						tx_q <= tx_q + 1'b1;
					end
				end
				default: state_q <= FO_IDLE;
			endcase
		end
	end

	// Buffer read stays enabled for the whole flush
	assign fmo_rd_o   = (state_q == FO_ADDR) || (state_q == FO_RD) || (state_q == FO_WR);
	assign buf_addr_o = buf_ch_q + buf_row_q + buf_x_q;

	always_comb begin
		ext_o       = '0;
		ext_o.wr    = (state_q == FO_WR);
		ext_o.addr  = cfg_i.ofm_base + ch_off_q + row_off_q + `DMA_ADDR_W'(tx_q) - 1'b1;
		ext_o.wdata = data_q;
	end

	assign done_o = (state_q == FO_DONE);

endmodule

`default_nettype wire

//--- source/dma_top.sv
// ##############################
// DMA engine top
// Controller, layer registers and
// the two tile walkers
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_top (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   start_i,
	input  wire dma_pkg::dma_op_e       op_i,
	input  wire logic [`DMA_DIM_W-1:0]  tx_i,
	input  wire logic [`DMA_DIM_W-1:0]  ty_i,
	input  wire logic                   ext_rvalid_i,
	input  wire logic [`DMA_DATA_W-1:0] ext_rdata_i,
	input  wire logic [`DMA_DATA_W-1:0] buf_rdata_i,
	output dma_pkg::ext_req_t           ext_req_o,
	output dma_pkg::buf_req_t           buf_req_o,
	output dma_pkg::layer_cfg_t         layer_cfg_o,
	output logic                        done_o
);

	logic                       load, fmi_start, fmo_start, fmi_done, fmo_done;
	logic [1:0]                 word_idx;
	logic [`DMA_DATA_W-1:0]     word, fmi_wdata;
	logic [`DMA_DIM_W-1:0]      tile_x, tile_y;
	dma_pkg::ext_req_t          fmi_ext, fmo_ext;
	dma_pkg::layer_cfg_t        cfg;
	dma_pkg::layer_geo_t        geo;
	logic                       fmi_wr, fmo_rd;
	logic [`DMA_BUF_ADDR_W-1:0] fmi_addr, fmo_addr;

	dma_ctrl i_dma_ctrl (
		.clk(clk), .rst(rst),
		.start_i(start_i), .op_i(op_i), .tx_i(tx_i), .ty_i(ty_i),
		.ext_rvalid_i(ext_rvalid_i), .ext_rdata_i(ext_rdata_i),
		.fmi_ext_i(fmi_ext), .fmo_ext_i(fmo_ext),
		.fmi_done_i(fmi_done), .fmo_done_i(fmo_done),
		.load_o(load), .word_idx_o(word_idx), .word_o(word),
		.fmi_start_o(fmi_start), .fmo_start_o(fmo_start),
		.tile_x_o(tile_x), .tile_y_o(tile_y),
		.ext_req_o(ext_req_o), .done_o(done_o)
	);

	dma_layer_regs i_dma_layer_regs (
		.clk(clk), .rst(rst),
		.load_i(load), .word_idx_i(word_idx), .word_i(word),
		.cfg_o(cfg), .geo_o(geo)
	);

	dma_fmi_loader i_dma_fmi_loader (
		.clk(clk), .rst(rst),
		.start_i(fmi_start), .tile_x_i(tile_x), .tile_y_i(tile_y),
		.cfg_i(cfg), .geo_i(geo),
		.ext_rvalid_i(ext_rvalid_i), .ext_rdata_i(ext_rdata_i),
		.ext_o(fmi_ext),
		.fmi_wr_o(fmi_wr), .buf_addr_o(fmi_addr), .buf_wdata_o(fmi_wdata),
		.done_o(fmi_done)
	);

	dma_fmo_writer i_dma_fmo_writer (
		.clk(clk), .rst(rst),
		.start_i(fmo_start), .tile_x_i(tile_x), .tile_y_i(tile_y),
		.cfg_i(cfg), .geo_i(geo),
		.buf_rdata_i(buf_rdata_i),
		.fmo_rd_o(fmo_rd), .buf_addr_o(fmo_addr),
		.ext_o(fmo_ext), .done_o(fmo_done)
	);

	assign layer_cfg_o = cfg; // Record for the main controller

	// Walkers never run together, output walker owns the address while reading
	assign buf_req_o = '{
		fmi_wr: fmi_wr,
		fmo_rd: fmo_rd,
		addr:   fmo_rd ? fmo_addr : fmi_addr,
		wdata:  fmi_wdata
	};

endmodule

`default_nettype wire

//--- verification/tb_dma.sv
// ##############################
// DMA engine testbench
// Memory and buffer models, reference
// walk order and strobe checker
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module tb_dma;

	localparam int M_IDLE = 0, M_INIT = 1, M_FMI = 2, M_FMO = 3;
	localparam int WD_CYCLES = (8 + 72 + 72 + 50 + 48 + 8 + 8) * 12 + 1000; // Elements x 12 plus margin

	logic clk, rst, start_i, ext_rvalid_i;
	dma_pkg::dma_op_e op_i;
	logic [`DMA_DIM_W-1:0] tx_i, ty_i;
	logic [`DMA_DATA_W-1:0] ext_rdata_i, buf_rdata_i;
	dma_pkg::ext_req_t ext_req_o;
	dma_pkg::buf_req_t buf_req_o;
	dma_pkg::layer_cfg_t layer_cfg_o;
	logic done_o;

	logic [31:0] mem [0:4095]; // External memory, 12 address bits used
	logic [31:0] obuf [0:4095]; // Output tile buffer
	int errors = 0, mode = M_IDLE, n_elem = 0, n_rd = 0;
	int pend = 0, rd_wait = 0;
	logic [11:0] rd_addr;
	// Expected layer record and tile origin
	int e_nix, e_niy, e_stride, e_nif, e_nof, e_ox, e_oy;
	logic [31:0] e_ifm, e_ofm;
	logic [31:0] r_eaddr, r_data;
	logic [11:0] r_baddr;
	logic r_real;

	dma_top i_dma_top (
		.clk(clk), .rst(rst), .start_i(start_i), .op_i(op_i), .tx_i(tx_i), .ty_i(ty_i),
		.ext_rvalid_i(ext_rvalid_i), .ext_rdata_i(ext_rdata_i), .buf_rdata_i(buf_rdata_i),
		.ext_req_o(ext_req_o), .buf_req_o(buf_req_o), .layer_cfg_o(layer_cfg_o), .done_o(done_o)
	);

	always #5 clk = ~clk;

	function automatic int min_int(input int a, input int b);
		return (a < b) ? a : b;
	endfunction

	// Tile width and height from the walk end rules
	function automatic void tile_dims(input int op, output int w, output int h);
		int nox, noy;
		nox = e_nix >> e_stride;
		noy = e_niy >> e_stride;
		if (op == M_FMI) begin
			w = min_int(`DMA_TIX, e_nix + `DMA_NKX / 2 - e_ox + 1);
			h = min_int(`DMA_TIY, e_niy + `DMA_NKY / 2 - e_oy + 1);
		end else begin
			w = min_int(`DMA_TOX >> e_stride, nox - e_ox + 1);
			h = min_int(`DMA_TOY >> e_stride, noy - e_oy + 1);
		end
	endfunction

	function automatic int elem_count(input int op);
		int w, h;
		tile_dims(op, w, h);
		return ((op == M_FMI) ? e_nif : e_nof) * w * h;
	endfunction

	// Expected addresses and data of element n, x fastest, then y, then channel
	function automatic void ref_elem(input int op, input int n, output logic [31:0] eaddr,
			output logic [11:0] baddr, output logic [31:0] data, output logic is_real);
		int w, h, c, r, x, y, tx, ty, nox, noy;
		tile_dims(op, w, h);
		c = n / (w * h) + 1;
		r = n % (w * h);
		y = r / w + 1;
		x = r % w + 1;
		tx = e_ox + x - 1;
		ty = e_oy + y - 1;
		nox = e_nix >> e_stride;
		noy = e_niy >> e_stride;
		if (op == M_FMI) begin
			is_real = (tx != 0) && (ty != 0) && (tx <= e_nix) && (ty <= e_niy);
			eaddr = e_ifm + (ty - 1) * e_nix + (tx - 1) + (c - 1) * e_nix * e_niy;
			baddr = 12'((c - 1) * `DMA_TIX * `DMA_TIY + (y - 1) * `DMA_TIX + x - 1);
			data = is_real ? mem[eaddr[11:0]] : 32'h0; // Padding writes zero
		end else begin
			is_real = 1'b1;
			eaddr = e_ofm + (ty - 1) * nox + (tx - 1) + (c - 1) * nox * noy;
			baddr = 12'((c - 1) * `DMA_TOX * `DMA_TOY + (y - 1) * (`DMA_TOX >> e_stride) + x - 1);
			data = obuf[baddr];
		end
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (exp === got) else begin
			errors++;
			$display("Fail %0t %s expected %h actual %h", $time, name, exp, got);
		end
	endtask

	// External memory, one read outstanding, latency 1 to 4
	always @(posedge clk) begin
		ext_rvalid_i <= 1'b0;
		if (pend != 0) begin
			rd_wait--;
			if (rd_wait == 0) begin
				ext_rvalid_i <= 1'b1;
				ext_rdata_i <= mem[rd_addr];
				pend = 0;
			end
		end
		if (ext_req_o.rd_req) begin
			pend = 1;
			rd_addr = ext_req_o.addr[11:0];
			rd_wait = $urandom % 4 + 1;
		end
		if (ext_req_o.wr)
			mem[ext_req_o.addr[11:0]] <= ext_req_o.wdata;
		if (buf_req_o.fmo_rd)
			buf_rdata_i <= obuf[buf_req_o.addr]; // One cycle read latency
	end

	// Strobe checker, samples away from the active edge
	always @(negedge clk) begin
		if (mode == M_IDLE) begin
			assert (!(ext_req_o.rd_req || ext_req_o.wr || buf_req_o.fmi_wr ||
					buf_req_o.fmo_rd || done_o)) else begin
				errors++;
				$display("Activity on a request, strobe or done_o while idle at %0t", $time);
			end
		end
		if (mode == M_FMI && ext_req_o.rd_req) begin
			ref_elem(M_FMI, n_elem, r_eaddr, r_baddr, r_data, r_real);
			n_rd++;
			assert (r_real) else begin
				errors++;
				$display("Read request for a padding position at %0t", $time);
			end
			compare_value("ext_req_o.addr", r_eaddr, ext_req_o.addr);
		end
		if (mode == M_FMI && buf_req_o.fmi_wr) begin
			ref_elem(M_FMI, n_elem, r_eaddr, r_baddr, r_data, r_real);
			compare_value("buf_req_o.addr", 32'(r_baddr), 32'(buf_req_o.addr));
			compare_value("buf_req_o.wdata", r_data, buf_req_o.wdata);
			n_elem++;
		end
		if (mode == M_FMO && ext_req_o.wr) begin
			ref_elem(M_FMO, n_elem, r_eaddr, r_baddr, r_data, r_real);
			compare_value("ext_req_o.addr", r_eaddr, ext_req_o.addr);
			compare_value("ext_req_o.wdata", r_data, ext_req_o.wdata);
			n_elem++;
		end
	end

	// Pulse start, wait for done_o, return the cycles from start to done
	task automatic run_op(input dma_pkg::dma_op_e op, input int m, input int ox, input int oy,
			output int cycles);
		time t0;
		int k;
		@(posedge clk);
		mode = m;
		n_elem = 0;
		n_rd = 0;
		e_ox = ox;
		e_oy = oy;
		start_i <= 1'b1;
		op_i <= op;
		tx_i <= 8'(ox);
		ty_i <= 8'(oy);
		t0 = $time;
		@(posedge clk);
		start_i <= 1'b0;
		k = 0;
		do begin
			@(negedge clk);
			k++;
		end while (!done_o && k < 2000);
		assert (done_o) else begin
			errors++;
			$display("No done_o after start of opcode %0d", op);
		end
		cycles = int'(($time - 5 - t0) / 10);
		@(posedge clk);
		mode = M_IDLE;
	endtask

	// Record at addresses 0 to 3, then OP_INIT and a field check
	task automatic load_layer(input int nix, input int niy, input int s, input int nif,
			input int nof, input logic [31:0] ifm, input logic [31:0] ofm);
		int cyc;
		mem[0] <= 32'(nix) | (32'(niy) << 8) | (32'(s) << 19);
		mem[1] <= 32'(nif) | (32'(nof) << 12);
		mem[2] <= ifm;
		mem[3] <= ofm;
		e_nix = nix;
		e_niy = niy;
		e_stride = s;
		e_nif = nif;
		e_nof = nof;
		e_ifm = ifm;
		e_ofm = ofm;
		run_op(dma_pkg::OP_INIT, M_INIT, 0, 0, cyc);
		compare_value("layer_cfg_o.nix", 32'(nix), 32'(layer_cfg_o.nix));
		compare_value("layer_cfg_o.niy", 32'(niy), 32'(layer_cfg_o.niy));
		compare_value("layer_cfg_o.stride", 32'(s), 32'(layer_cfg_o.stride));
		compare_value("layer_cfg_o.nif", 32'(nif), 32'(layer_cfg_o.nif));
		compare_value("layer_cfg_o.nof", 32'(nof), 32'(layer_cfg_o.nof));
		compare_value("layer_cfg_o.ifm_base", ifm, layer_cfg_o.ifm_base);
		compare_value("layer_cfg_o.ofm_base", ofm, layer_cfg_o.ofm_base);
	endtask

	// Input tile, element and read counts against the reference
	task automatic load_tile(input int ox, input int oy);
		int cyc, reals;
		run_op(dma_pkg::OP_LOAD_FMI, M_FMI, ox, oy, cyc);
		reals = 0;
		for (int n = 0; n < elem_count(M_FMI); n++) begin
			ref_elem(M_FMI, n, r_eaddr, r_baddr, r_data, r_real);
			reals += int'(r_real);
		end
		compare_value("fmi_wr count", 32'(elem_count(M_FMI)), 32'(n_elem));
		compare_value("rd_req count", 32'(reals), 32'(n_rd));
	endtask

	task automatic flush_tile(input int ox, input int oy);
		int cyc, num;
		run_op(dma_pkg::OP_STORE_FMO, M_FMO, ox, oy, cyc);
		num = elem_count(M_FMO);
		compare_value("wr count", 32'(num), 32'(n_elem));
		compare_value("done_o latency", 32'(2 * num + 3), 32'(cyc));
	endtask

	initial begin
		WATCHDOG: begin
			#(WD_CYCLES * 10);
			$display("Watchdog expired before the tests ended");
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst <= 1'b1;
		start_i <= 1'b0;
		op_i <= dma_pkg::OP_INIT;
		tx_i <= '0;
		ty_i <= '0;
		ext_rvalid_i <= 1'b0;
		ext_rdata_i <= '0;
		buf_rdata_i <= '0;
		void'($urandom(32'h17f3_e470));
		for (int a = 0; a < 4096; a++) begin
			mem[a] <= $urandom;
			obuf[a] = $urandom;
		end
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		repeat (3) @(posedge clk); // Idle check covers reset and after
		load_layer(10, 8, 0, 2, 3, 32'h100, 32'h800);
		load_tile(3, 3);  // Interior, every pixel real
		load_tile(0, 0);  // Top left halo
		load_tile(7, 5);  // Bottom right halo, row 9 lies below the map
		flush_tile(1, 1);
		load_layer(10, 8, 1, 2, 2, 32'h100, 32'hA00);
		flush_tile(2, 2); // Stride 2
		@(posedge clk);
		start_i <= 1'b1;
		op_i <= dma_pkg::dma_op_e'(3'd3); // Opcode with no operation
		@(posedge clk);
		start_i <= 1'b0;
		repeat (20) @(posedge clk);
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
source/dma_pkg.sv
source/dma_layer_regs.sv
source/dma_ctrl.sv
source/dma_fmi_loader.sv
source/dma_fmo_writer.sv
source/dma_top.sv
verification/tb_dma.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dma
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
FILELIST  ?= compile.f

SRCS := include/dma_params.svh $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)
